/* axi_gpgpu_ctl.f */
gpgpu_ctl_pkg.sv
axi_write_addr_table.sv
axi_write_engine.sv
axi_read_addr_table.sv
axi_read_engine.sv
core_config_regs.sv
axi_gpgpu_ctl.sv
tb_axi_gpgpu_ctl.sv

/* axi_gpgpu_ctl.sv */
//--------------------------------------------------------------------------
// AXI slave configuration block for the GPGPU core
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module axi_gpgpu_ctl import gpgpu_ctl_pkg::*; (
   input  logic    clk,
   input  logic    reset_n,
   input  aw_req_t aw_req,
   input  logic    aw_valid,
   output logic    aw_ready,
   input  w_beat_t w_beat,
   input  logic    w_valid,
   output logic    w_ready,
   output b_rsp_t  b_rsp,
   output logic    b_valid,
   input  logic    b_ready,
   input  ar_req_t ar_req,
   input  logic    ar_valid,
   output logic    ar_ready,
   output r_beat_t r_beat,
   output logic    r_valid,
   input  logic    r_ready,
   output logic    core_reset,
   output data_t   reset_pc
);

   //-----------------------------------------------------------------------
   // internal wiring
   //-----------------------------------------------------------------------
   logic [ID_COUNT-1:0] wr_pending;
   addr_t               wr_slot_addr [ID_COUNT];
   cnt_t                wr_slot_left [ID_COUNT];
   logic [ID_COUNT-1:0] wr_advance;
   logic [ID_COUNT-1:0] wr_clear;
   logic [ID_COUNT-1:0] rd_pending;
   addr_t               rd_slot_addr [ID_COUNT];
   cnt_t                rd_slot_len [ID_COUNT];
   logic [ID_COUNT-1:0] rd_clear;
   reg_wr_t             reg_wr;
   logic                reg_we;
   addr_t               rd_addr;
   data_t               rd_data;

   axi_write_addr_table u_write_addr_table (
      .clk       (clk),
      .reset_n   (reset_n),
      .aw_req    (aw_req),
      .aw_valid  (aw_valid),
      .aw_ready  (aw_ready),
      .advance   (wr_advance),
      .clear     (wr_clear),
      .pending   (wr_pending),
      .slot_addr (wr_slot_addr),
      .slot_left (wr_slot_left)
   );

   axi_write_engine u_write_engine (
      .clk       (clk),
      .reset_n   (reset_n),
      .w_beat    (w_beat),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .b_rsp     (b_rsp),
      .b_valid   (b_valid),
      .b_ready   (b_ready),
      .pending   (wr_pending),
      .slot_addr (wr_slot_addr),
      .slot_left (wr_slot_left),
      .advance   (wr_advance),
      .clear     (wr_clear),
      .reg_wr    (reg_wr),
      .reg_we    (reg_we)
   );

   axi_read_addr_table u_read_addr_table (
      .clk       (clk),
      .reset_n   (reset_n),
      .ar_req    (ar_req),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready),
      .clear     (rd_clear),
      .pending   (rd_pending),
      .slot_addr (rd_slot_addr),
      .slot_len  (rd_slot_len)
   );

   axi_read_engine u_read_engine (
      .clk       (clk),
      .reset_n   (reset_n),
      .pending   (rd_pending),
      .slot_addr (rd_slot_addr),
      .slot_len  (rd_slot_len),
      .clear     (rd_clear),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .r_beat    (r_beat),
      .r_valid   (r_valid),
      .r_ready   (r_ready)
   );

   core_config_regs u_config_regs (
      .clk        (clk),
      .reset_n    (reset_n),
      .reg_wr     (reg_wr),
      .reg_we     (reg_we),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .core_reset (core_reset),
      .reset_pc   (reset_pc)
   );

endmodule

/* axi_read_addr_table.sv */
//--------------------------------------------------------------------------
// AXI read address table
// one stored read address and burst length per read id
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module axi_read_addr_table import gpgpu_ctl_pkg::*; (
   input  logic                clk,
   input  logic                reset_n,
   input  ar_req_t             ar_req,
   input  logic                ar_valid,
   output logic                ar_ready,
   input  logic [ID_COUNT-1:0] clear,
   output logic [ID_COUNT-1:0] pending,
   output addr_t               slot_addr [ID_COUNT],
   output cnt_t                slot_len [ID_COUNT]
);

   logic ar_take;

   assign ar_ready = ~pending[ar_req.id];
   assign ar_take  = ar_valid && ar_ready;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         pending <= '0;
      end else begin
         pending <= pending & ~clear;          // last beat taken
         if (ar_take)
            pending[ar_req.id] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_take) begin
         slot_addr[ar_req.id] <= ar_req.addr;
         slot_len[ar_req.id]  <= cnt_t'(ar_req.len) + cnt_t'(1);   // beats
      end
   end

endmodule

/* axi_read_engine.sv */
//--------------------------------------------------------------------------
// AXI read data engine
// serves the highest pending id through a two word prefetch pipeline
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module axi_read_engine import gpgpu_ctl_pkg::*; (
   input  logic                clk,
   input  logic                reset_n,
   input  logic [ID_COUNT-1:0] pending,
   input  addr_t               slot_addr [ID_COUNT],
   input  cnt_t                slot_len [ID_COUNT],
   output logic [ID_COUNT-1:0] clear,
   output addr_t               rd_addr,
   input  data_t               rd_data,
   output r_beat_t             r_beat,
   output logic                r_valid,
   input  logic                r_ready
);

   typedef enum logic [1:0] {R_IDLE, R_FILL, R_BURST, R_LAST} r_state_t;

   r_state_t state;
   id_t      cur_id;
   id_t      pick_id;
   cnt_t     rd_ptr;                           // words fetched so far
   cnt_t     beats_left;                       // including the beat on the bus
   data_t    pre_data;                         // first prefetch stage
   logic     nextword;
   logic     fill_done;

   // highest pending id wins
   always_comb begin
      pick_id = '0;
      for (int i = 0; i < ID_COUNT; i++) begin
         if (pending[i])
            pick_id = id_t'(i);
      end
   end

   assign nextword  = (state == R_FILL) || (state == R_BURST && r_ready);
   assign fill_done = (state == R_FILL) && (rd_ptr == cnt_t'(1));
   assign rd_addr   = slot_addr[cur_id] + addr_t'(rd_ptr);

   always_comb begin
      clear = '0;
      if (state == R_LAST && r_ready)
         clear[cur_id] = 1'b1;                 // free slot with the last beat
   end

   //-----------------------------------------------------------------------
   // burst control
   //-----------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state      <= R_IDLE;
         cur_id     <= '0;
         rd_ptr     <= '0;
         beats_left <= '0;
         r_valid    <= 1'b0;
      end else begin
         if (nextword)
            rd_ptr <= rd_ptr + cnt_t'(1);
         case (state)
            R_IDLE: begin
               if (|pending) begin
                  state  <= R_FILL;
                  cur_id <= pick_id;
                  rd_ptr <= '0;
               end
            end
            R_FILL: begin
               if (fill_done) begin
                  r_valid    <= 1'b1;
                  beats_left <= slot_len[cur_id];
                  state      <= (slot_len[cur_id] == cnt_t'(1)) ? R_LAST : R_BURST;
               end
            end
            R_BURST: begin
               if (r_ready) begin
                  beats_left <= beats_left - cnt_t'(1);
                  if (beats_left == cnt_t'(2))
                     state <= R_LAST;
               end
            end
            R_LAST: begin
               if (r_ready) begin
                  r_valid <= 1'b0;
                  state   <= R_IDLE;
               end
            end
         endcase
      end
   end

   // data pipeline, frozen while r_ready is low
   always_ff @(posedge clk) begin
      if (nextword) begin
         pre_data    <= rd_data;
         r_beat.data <= pre_data;
      end
      if (fill_done) begin
         r_beat.id   <= cur_id;
         r_beat.last <= (slot_len[cur_id] == cnt_t'(1));
      end else if (state == R_BURST && r_ready) begin
         r_beat.last <= (beats_left == cnt_t'(2));
      end
   end

endmodule

/* axi_write_addr_table.sv */
//--------------------------------------------------------------------------
// AXI write address table
// one stored address and remaining beat count per write id
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module axi_write_addr_table import gpgpu_ctl_pkg::*; (
   input  logic                clk,
   input  logic                reset_n,
   input  aw_req_t             aw_req,
   input  logic                aw_valid,
   output logic                aw_ready,
   input  logic [ID_COUNT-1:0] advance,
   input  logic [ID_COUNT-1:0] clear,
   output logic [ID_COUNT-1:0] pending,
   output addr_t               slot_addr [ID_COUNT],
   output cnt_t                slot_left [ID_COUNT]
);

   logic aw_take;

   assign aw_ready = ~pending[aw_req.id];     // slot free for this id
   assign aw_take  = aw_valid && aw_ready;

   // valid bits
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         pending <= '0;
      end else begin
         pending <= pending & ~clear;          // burst finished
         if (aw_take)
            pending[aw_req.id] <= 1'b1;
      end
   end

   // address and remaining beats, accept and advance never hit one slot
   always_ff @(posedge clk) begin
      for (int i = 0; i < ID_COUNT; i++) begin
         if (aw_take && aw_req.id == id_t'(i)) begin
            slot_addr[i] <= aw_req.addr;
            slot_left[i] <= cnt_t'(aw_req.len) + cnt_t'(1);
         end else if (advance[i]) begin
            slot_addr[i] <= slot_addr[i] + addr_t'(1);   // next word
            slot_left[i] <= slot_left[i] - cnt_t'(1);
         end
      end
   end

endmodule

/* axi_write_engine.sv */
//--------------------------------------------------------------------------
// AXI write data engine
// single and burst writes into the register bank, early data buffer per
// id and write response generation
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module axi_write_engine import gpgpu_ctl_pkg::*; (
   input  logic                clk,
   input  logic                reset_n,
   input  w_beat_t             w_beat,
   input  logic                w_valid,
   output logic                w_ready,
   output b_rsp_t              b_rsp,
   output logic                b_valid,
   input  logic                b_ready,
   input  logic [ID_COUNT-1:0] pending,
   input  addr_t               slot_addr [ID_COUNT],
   input  cnt_t                slot_left [ID_COUNT],
   output logic [ID_COUNT-1:0] advance,
   output logic [ID_COUNT-1:0] clear,
   output reg_wr_t             reg_wr,
   output logic                reg_we
);

   typedef enum logic {W_IDLE, W_BURST} w_state_t;

   w_state_t            state;
   id_t                 cur_id;               // id of the open burst

   logic [ID_COUNT-1:0] buf_valid;
   data_t               buf_data [ID_COUNT];
   strb_t               buf_strb [ID_COUNT];
   logic [ID_COUNT-1:0] buf_last;

   logic [ID_COUNT-1:0] drain_hit;
   id_t                 drain_id;
   logic                drain;
   logic                blocked;
   logic                w_take;
   logic                beat_wr;
   logic                beat_buf;
   logic                wr_fire;
   id_t                 wr_id;
   logic                wr_last;
   logic                wr_end;
   logic                wr_ok;

   //-----------------------------------------------------------------------
   // beat selection
   //-----------------------------------------------------------------------
   assign blocked   = b_valid && !b_ready;     // response not yet taken
   assign drain_hit = buf_valid & pending;

   always_comb begin
      drain_id = '0;
      for (int i = 0; i < ID_COUNT; i++) begin
         if (drain_hit[i])
            drain_id = id_t'(i);
      end
   end

   assign drain = (state == W_IDLE) && (|drain_hit) && !blocked;

   always_comb begin
      if (blocked || drain)
         w_ready = 1'b0;
      else if (state == W_BURST)
         w_ready = (w_beat.id == cur_id);      // no interleaving inside a burst
      else
         w_ready = !buf_valid[w_beat.id];
   end

   assign w_take   = w_valid && w_ready;
   assign beat_wr  = w_take && pending[w_beat.id];
   assign beat_buf = w_take && !pending[w_beat.id];   // data before address

   assign wr_fire = drain || beat_wr;
   assign wr_id   = drain ? drain_id : w_beat.id;
   assign wr_last = drain ? buf_last[drain_id] : w_beat.last;
   assign wr_end  = wr_fire && (wr_last || slot_left[wr_id] == cnt_t'(1));
   assign wr_ok   = wr_last && slot_left[wr_id] == cnt_t'(1);

   // register bank write port
   always_comb begin
      reg_we      = wr_fire;
      reg_wr.addr = slot_addr[wr_id];
      reg_wr.data = drain ? buf_data[drain_id] : w_beat.data;
      reg_wr.strb = drain ? buf_strb[drain_id] : w_beat.strb;
   end

   always_comb begin
      advance = '0;
      clear   = '0;
      if (wr_fire && !wr_end)
         advance[wr_id] = 1'b1;
      if (wr_end)
         clear[wr_id] = 1'b1;
   end

   //-----------------------------------------------------------------------
   // state, buffer and response
   //-----------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state     <= W_IDLE;
         cur_id    <= '0;
         buf_valid <= '0;
         b_valid   <= 1'b0;
      end else begin
         if (wr_end) begin
            state <= W_IDLE;
         end else if (wr_fire) begin
            state  <= W_BURST;
            cur_id <= wr_id;
         end
         if (beat_buf)
            buf_valid[w_beat.id] <= 1'b1;
         if (drain)
            buf_valid[drain_id] <= 1'b0;
         if (wr_end)
            b_valid <= 1'b1;
         else if (b_ready)
            b_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (beat_buf) begin
         buf_data[w_beat.id] <= w_beat.data;
         buf_strb[w_beat.id] <= w_beat.strb;
         buf_last[w_beat.id] <= w_beat.last;
      end
      if (wr_end) begin
         b_rsp.id   <= wr_id;
         b_rsp.resp <= wr_ok ? RESP_OKAY : RESP_SLVERR;   // length mismatch
      end
   end

endmodule

/* core_config_regs.sv */
//--------------------------------------------------------------------------
// Core configuration register bank
// control word with self clearing core reset, and the core start address
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module core_config_regs import gpgpu_ctl_pkg::*; (
   input  logic    clk,
   input  logic    reset_n,
   input  reg_wr_t reg_wr,
   input  logic    reg_we,
   input  addr_t   rd_addr,
   output data_t   rd_data,
   output logic    core_reset,
   output data_t   reset_pc
);

   data_t regs [REG_COUNT];

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         for (int i = 0; i < REG_COUNT; i++)
            regs[i] <= '0;
      end else begin
         for (int i = 0; i < REG_COUNT; i++) begin
            if (reg_we && reg_wr.addr == addr_t'(i)) begin
               for (int b = 0; b < STRB_W; b++) begin
                  if (reg_wr.strb[b])
                     regs[i][8*b +: 8] <= reg_wr.data[8*b +: 8];   // byte lane
               end
            end else if (i == REG_CTL && regs[i] == data_t'(1)) begin
               regs[i] <= '0;                  // one cycle reset pulse
            end
         end
      end
   end

   // out of range reads give zero
   always_comb begin
      rd_data = '0;
      for (int i = 0; i < REG_COUNT; i++) begin
         if (rd_addr == addr_t'(i))
            rd_data = regs[i];
      end
   end

   assign core_reset = (regs[REG_CTL] == data_t'(1));
   assign reset_pc   = regs[REG_PC];

endmodule

/* gpgpu_ctl_pkg.sv */
//--------------------------------------------------------------------------
// GPGPU control block shared definitions
// widths, counts, response codes and the AXI channel payload structs
//--------------------------------------------------------------------------
package gpgpu_ctl_pkg;

   localparam int ID_W      = 4;               // AXI id width
   localparam int ID_COUNT  = 16;              // one slot per id
   localparam int ADDR_W    = 6;               // word address
   localparam int DATA_W    = 32;
   localparam int STRB_W    = 4;               // one strobe per byte
   localparam int LEN_W     = 4;               // burst length is len + 1
   localparam int CNT_W     = 5;               // holds up to 16 beats
   localparam int REG_COUNT = 2;
   localparam int REG_CTL   = 0;               // core control word
   localparam int REG_PC    = 1;               // core start address

   localparam logic [1:0] RESP_OKAY   = 2'd0;
   localparam logic [1:0] RESP_SLVERR = 2'd2;

   typedef logic [ID_W-1:0]   id_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [CNT_W-1:0]  cnt_t;

   //-----------------------------------------------------------------------
   // channel payloads
   //-----------------------------------------------------------------------
   typedef struct packed {
      id_t              id;
      addr_t            addr;
      logic [LEN_W-1:0] len;
   } aw_req_t;

   typedef struct packed {
      id_t              id;
      addr_t            addr;
      logic [LEN_W-1:0] len;
   } ar_req_t;

   typedef struct packed {
      id_t   id;
      data_t data;
      strb_t strb;
      logic  last;
   } w_beat_t;

   typedef struct packed {
      id_t        id;
      logic [1:0] resp;
   } b_rsp_t;

   typedef struct packed {
      id_t   id;
      data_t data;
      logic  last;
   } r_beat_t;

   // write port into the register bank
   typedef struct packed {
      addr_t addr;
      data_t data;
      strb_t strb;
   } reg_wr_t;

endpackage

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_axi_gpgpu_ctl \
   -f axi_gpgpu_ctl.f -o sim_axi_gpgpu_ctl
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_axi_gpgpu_ctl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* tb_axi_gpgpu_ctl.sv */
//--------------------------------------------------------------------------
// Testbench for the AXI GPGPU control block
// random single and burst writes, early data, core reset and read bursts
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_axi_gpgpu_ctl import gpgpu_ctl_pkg::*; ();

   localparam int WAIT_LIMIT = 400;            // cycles per handshake wait

   logic    clk;
   logic    reset_n;
   aw_req_t aw_req;
   logic    aw_valid;
   logic    aw_ready;
   w_beat_t w_beat;
   logic    w_valid;
   logic    w_ready;
   b_rsp_t  b_rsp;
   logic    b_valid;
   logic    b_ready;
   ar_req_t ar_req;
   logic    ar_valid;
   logic    ar_ready;
   r_beat_t r_beat;
   logic    r_valid;
   logic    r_ready;
   logic    core_reset;
   data_t   reset_pc;

   logic [31:0] rng;
   data_t       model [REG_COUNT];             // expected register contents
   r_beat_t     exp_q [ID_COUNT][$];           // expected read beats per id
   int          outstanding;
   int          value_errors;
   int          other_errors;
   int          exp_pulses;
   int          seen_pulses = 0;

   axi_gpgpu_ctl u_axi_gpgpu_ctl (
      .clk        (clk),
      .reset_n    (reset_n),
      .aw_req     (aw_req),
      .aw_valid   (aw_valid),
      .aw_ready   (aw_ready),
      .w_beat     (w_beat),
      .w_valid    (w_valid),
      .w_ready    (w_ready),
      .b_rsp      (b_rsp),
      .b_valid    (b_valid),
      .b_ready    (b_ready),
      .ar_req     (ar_req),
      .ar_valid   (ar_valid),
      .ar_ready   (ar_ready),
      .r_beat     (r_beat),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .core_reset (core_reset),
      .reset_pc   (reset_pc)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // core reset pulse count and write back-pressure
   always @(negedge clk) begin
      if (reset_n && core_reset)
         seen_pulses++;
      if (reset_n && b_valid && !b_ready && w_ready) begin
         other_errors++;
         $display("w_ready is high while the write response is stalled");
      end
   end

   //-----------------------------------------------------------------------
   // random numbers and register model
   //-----------------------------------------------------------------------
   function automatic logic [31:0] next_rand();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   function automatic int rand_below(int n);
      logic [31:0] r;
      r = next_rand();
      return int'(r[30:16]) % n;
   endfunction

   function automatic data_t model_read(addr_t a);
      data_t d;
      d = '0;                                  // out of range reads zero
      for (int i = 0; i < REG_COUNT; i++) begin
         if (a == addr_t'(i))
            d = model[i];
      end
      return d;
   endfunction

   function automatic void model_write(addr_t a, data_t d, strb_t s);
      for (int i = 0; i < REG_COUNT; i++) begin
         if (a == addr_t'(i)) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (s[b])
                  model[i][8*b +: 8] = d[8*b +: 8];
            end
         end
      end
      if (model[REG_CTL] == data_t'(1)) begin
         exp_pulses++;                         // control word clears itself
         model[REG_CTL] = '0;
      end
   endfunction

   //-----------------------------------------------------------------------
   // compare tasks
   //-----------------------------------------------------------------------
   task automatic check_b(input b_rsp_t got, input b_rsp_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("Fail b_rsp: id %h resp %h, expected id %h resp %h",
                  got.id, got.resp, exp.id, exp.resp);
      end
   endtask

   task automatic check_r(input r_beat_t got, input r_beat_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("Fail r_beat: id %h data %h last %h, expected id %h data %h last %h",
                  got.id, got.data, got.last, exp.id, exp.data, exp.last);
      end
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("Fail %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic abort_run(input string what);
      $display("timeout while waiting for %s", what);
      $display("errors: %0d value mismatches, %0d other failures",
               value_errors, other_errors + 1);
      $display("TEST FAIL");
      $finish;
   endtask

   //-----------------------------------------------------------------------
   // channel drivers
   //-----------------------------------------------------------------------
   task automatic send_aw(input aw_req_t req);
      int n;
      n = 0;
      @(posedge clk);
      aw_req   <= req;
      aw_valid <= 1'b1;
      @(negedge clk);
      while (!aw_ready) begin
         n++;
         if (n > WAIT_LIMIT)
            abort_run("aw_ready");
         @(negedge clk);
      end
      @(posedge clk);                          // address taken here
      aw_valid <= 1'b0;
   endtask

   task automatic send_w(input w_beat_t beat);
      int n;
      n = 0;
      @(posedge clk);
      w_beat  <= beat;
      w_valid <= 1'b1;
      @(negedge clk);
      while (!w_ready) begin
         n++;
         if (n > WAIT_LIMIT)
            abort_run("w_ready");
         @(negedge clk);
      end
      @(posedge clk);
      w_valid <= 1'b0;
   endtask

   task automatic send_ar(input ar_req_t req);
      int n;
      n = 0;
      @(posedge clk);
      ar_req   <= req;
      ar_valid <= 1'b1;
      @(negedge clk);
      while (!ar_ready) begin
         n++;
         if (n > WAIT_LIMIT)
            abort_run("ar_ready");
         @(negedge clk);
      end
      @(posedge clk);
      ar_valid <= 1'b0;
   endtask

   task automatic wait_b(input id_t id, input logic [1:0] resp);
      int     n;
      b_rsp_t exp;
      n = 0;
      exp.id   = id;
      exp.resp = resp;
      @(posedge clk);
      b_ready <= 1'b1;
      @(negedge clk);
      while (!b_valid) begin
         n++;
         if (n > WAIT_LIMIT)
            abort_run("b_valid");
         @(negedge clk);
      end
      check_b(b_rsp, exp);
      @(posedge clk);
      b_ready <= 1'b0;
   endtask

   //-----------------------------------------------------------------------
   // transactions
   //-----------------------------------------------------------------------
   task automatic write_word(input id_t id, input addr_t addr, input data_t data,
                             input strb_t strb, input logic early);
      aw_req_t req;
      w_beat_t beat;
      req.id    = id;
      req.addr  = addr;
      req.len   = '0;
      beat.id   = id;
      beat.data = data;
      beat.strb = strb;
      beat.last = 1'b1;
      if (early) begin
         send_w(beat);                         // lands in the early buffer
         send_aw(req);
      end else begin
         send_aw(req);
         send_w(beat);
      end
      model_write(addr, data, strb);
      wait_b(id, RESP_OKAY);
   endtask

   task automatic write_burst(input id_t id, input addr_t addr, input int nbeats,
                              input int nsent);
      aw_req_t req;
      w_beat_t beat;
      req.id   = id;
      req.addr = addr;
      req.len  = LEN_W'(nbeats - 1);
      send_aw(req);
      for (int k = 0; k < nsent; k++) begin
         beat.id   = id;
         beat.data = next_rand();
         beat.strb = strb_t'(rand_below(16));
         beat.last = (k == nsent - 1);         // early when nsent is short
         send_w(beat);
         model_write(addr + addr_t'(k), beat.data, beat.strb);
      end
      wait_b(id, (nsent == nbeats) ? RESP_OKAY : RESP_SLVERR);
   endtask

   task automatic queue_read(input id_t id, input addr_t addr, input int nbeats);
      ar_req_t req;
      r_beat_t e;
      for (int k = 0; k < nbeats; k++) begin
         e.id   = id;
         e.data = model_read(addr + addr_t'(k));
         e.last = (k == nbeats - 1);
         exp_q[id].push_back(e);
         outstanding++;
      end
      req.id   = id;
      req.addr = addr;
      req.len  = LEN_W'(nbeats - 1);
      send_ar(req);
   endtask

   // random r_ready stalls until every queued beat is back
   task automatic collect_reads();
      int      n;
      r_beat_t got;
      n = 0;
      while (outstanding > 0) begin
         @(posedge clk);
         r_ready <= (rand_below(4) != 0);
         @(negedge clk);
         if (r_valid && r_ready) begin
            got = r_beat;
            n   = 0;
            if (exp_q[got.id].size() == 0) begin
               other_errors++;
               $display("read beat for id %0h that was never requested", got.id);
            end else begin
               check_r(got, exp_q[got.id].pop_front());
               outstanding--;
            end
         end else begin
            n++;
            if (n > WAIT_LIMIT)
               abort_run("read data");
         end
      end
      @(posedge clk);
      r_ready <= 1'b0;
      @(negedge clk);
      if (r_valid) begin
         other_errors++;
         $display("read data still valid after the last expected beat");
      end
   endtask

   //-----------------------------------------------------------------------
   // test sequence
   //-----------------------------------------------------------------------
   initial begin
      int    nb;
      int    ns;
      int    pulses_before;
      id_t   ida;
      id_t   idb;
      addr_t a;
      reset_n      = 1'b0;
      aw_req       = '0;
      aw_valid     = 1'b0;
      w_beat       = '0;
      w_valid      = 1'b0;
      b_ready      = 1'b0;
      ar_req       = '0;
      ar_valid     = 1'b0;
      r_ready      = 1'b0;
      rng          = 32'h9dd6;
      outstanding  = 0;
      value_errors = 0;
      other_errors = 0;
      exp_pulses   = 0;
      for (int i = 0; i < REG_COUNT; i++)
         model[i] = '0;
      repeat (5) @(posedge clk);
      reset_n <= 1'b1;
      @(posedge clk);

      // single writes with read back
      for (int t = 0; t < 40; t++) begin
         a = addr_t'(rand_below(4));
         write_word(id_t'(rand_below(16)), a, next_rand(), strb_t'(rand_below(16)), 1'b0);
         queue_read(id_t'(rand_below(16)), a, 1);
         collect_reads();
      end

      // bursts with some closed early by wlast
      for (int t = 0; t < 24; t++) begin
         ida = id_t'(rand_below(16));
         nb  = 1 + rand_below(4);
         ns  = nb;
         if (nb > 1 && rand_below(2) == 1)
            ns = 1 + rand_below(nb - 1);
         write_burst(ida, addr_t'(rand_below(4)), nb, ns);
         queue_read(ida, '0, 4);               // both registers and two holes
         collect_reads();
      end

      // data before address
      for (int t = 0; t < 8; t++) begin
         write_word(id_t'(rand_below(16)), addr_t'(rand_below(2)), next_rand(), 4'hf, 1'b1);
         queue_read(id_t'(rand_below(16)), '0, 2);
         collect_reads();
      end

      // core reset pulse and start address
      pulses_before = seen_pulses;
      write_word(id_t'(rand_below(16)), addr_t'(REG_CTL), data_t'(1), 4'hf, 1'b0);
      repeat (2) @(negedge clk);
      if (seen_pulses - pulses_before != 1) begin
         other_errors++;
         $display("core_reset was high for %0d cycles after the control write",
                  seen_pulses - pulses_before);
      end
      queue_read(id_t'(rand_below(16)), addr_t'(REG_CTL), 1);
      collect_reads();
      write_word(id_t'(rand_below(16)), addr_t'(REG_PC), next_rand(), 4'hf, 1'b0);
      @(negedge clk);
      check_data("reset_pc", reset_pc, model_read(addr_t'(REG_PC)));

      // two read bursts in flight
      for (int t = 0; t < 12; t++) begin
         ida = id_t'(rand_below(16));
         idb = ida + id_t'(1 + rand_below(15));   // always a different id
         queue_read(ida, addr_t'(rand_below(4)), 1 + rand_below(4));
         queue_read(idb, addr_t'(rand_below(4)), 1 + rand_below(4));
         collect_reads();
      end

      if (seen_pulses != exp_pulses) begin
         other_errors++;
         $display("core_reset was high for %0d cycles in total, %0d expected",
                  seen_pulses, exp_pulses);
      end
      $display("errors: %0d value mismatches, %0d other failures",
               value_errors, other_errors);
      if (value_errors + other_errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule
